/* logic/access_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module access_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  bus_pkg::apb_req_t   apb_i,
    output bus_pkg::access_t    acc_o,
    output logic                acc_vld_o
);

    logic                   setup;
    reg_map_pkg::target_e   target;

    // setup phase of an APB transfer
    assign setup = apb_i.psel && !apb_i.penable;

    // address classification
    always_comb begin
        if (apb_i.paddr[reg_map_pkg::EXT_SEL_BIT]) begin
            target = reg_map_pkg::TGT_EXT;
        end else begin
            case (apb_i.paddr)
                reg_map_pkg::ERR_ADDR_LO_ADDR: target = reg_map_pkg::TGT_ERR_ADDR_LO;
                reg_map_pkg::ERR_ADDR_HI_ADDR: target = reg_map_pkg::TGT_ERR_ADDR_HI;
                reg_map_pkg::TMR_THR_ADDR:     target = reg_map_pkg::TGT_TMR_THR;
                reg_map_pkg::ERR_STAT_ADDR:    target = reg_map_pkg::TGT_ERR_STAT;
                default:                       target = reg_map_pkg::TGT_UNMAPPED;
            endcase
        end
    end

    // one cycle strobe after the setup sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_vld_o <= 1'b0;
        end else begin
            acc_vld_o <= setup;
        end
    end

    // access payload, held until the next setup phase
    always_ff @(posedge clk) begin
        if (setup) begin
            acc_o.op      <= apb_i.pwrite ? bus_pkg::OP_WRITE : bus_pkg::OP_READ;
            acc_o.target  <= target;
            acc_o.addr    <= apb_i.paddr;
            acc_o.wr_data <= apb_i.pwdata;
        end
    end

endmodule

`default_nettype wire

/* logic/access_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module access_fsm #(
    parameter int unsigned TMR_W = 32
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  bus_pkg::access_t                    acc_i,
    input  logic                                acc_vld_i,
    input  logic [TMR_W-1:0]                    tmr_thr_i,
    output bus_pkg::native_req_t                ext_req_o,
    input  bus_pkg::native_rsp_t                ext_rsp_i,
    output bus_pkg::reg_acc_t                   reg_acc_o,
    input  logic [reg_map_pkg::DATA_W-1:0]      reg_rd_data_i,
    output bus_pkg::err_evt_t                   err_evt_o,
    output bus_pkg::apb_rsp_t                   apb_o
);

    bus_pkg::fsm_state_e                state_q;
    bus_pkg::fsm_state_e                state_d;
    logic [TMR_W-1:0]                   tmr_cnt_q;
    logic                               rsp_err_q;
    logic [reg_map_pkg::DATA_W-1:0]     rsp_data_q;
    logic                               is_ext;
    logic                               is_int;
    logic                               is_wr;
    logic                               in_req;
    logic                               ext_busy;
    logic                               ext_ack;
    logic                               tmout;

    assign is_ext = acc_i.target == reg_map_pkg::TGT_EXT;
    assign is_int = !is_ext && (acc_i.target != reg_map_pkg::TGT_UNMAPPED);
    assign is_wr  = acc_i.op == bus_pkg::OP_WRITE;
    assign in_req = state_q == bus_pkg::ST_REQ;

    // external request outstanding from REQ until the end of WAIT
    assign ext_busy = is_ext && (in_req || (state_q == bus_pkg::ST_WAIT));
    // stray acks are dropped here
    assign ext_ack  = ext_busy && ext_rsp_i.ack_vld;
    // ack in the same cycle beats the timeout
    assign tmout    = (state_q == bus_pkg::ST_WAIT) && !ext_rsp_i.ack_vld &&
                      (tmr_cnt_q == tmr_thr_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            bus_pkg::ST_IDLE: begin
                if (acc_vld_i) begin
                    state_d = bus_pkg::ST_REQ;
                end
            end
            bus_pkg::ST_REQ: begin
                // internal and unmapped accesses finish right here
                if (!is_ext || ext_ack) begin
                    state_d = bus_pkg::ST_RESP;
                end else begin
                    state_d = bus_pkg::ST_WAIT;
                end
            end
            bus_pkg::ST_WAIT: begin
                if (ext_ack || tmout) begin
                    state_d = bus_pkg::ST_RESP;
                end
            end
            default: begin
                state_d = bus_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= bus_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // timeout counter, restarted for every access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmr_cnt_q <= '0;
        end else if (in_req) begin
            tmr_cnt_q <= '0;
        end else if (state_q == bus_pkg::ST_WAIT) begin
            tmr_cnt_q <= tmr_cnt_q + TMR_W'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_err_q <= 1'b0;
        end else if ((in_req && !is_ext) || ext_ack) begin
            rsp_err_q <= 1'b0;
        end else if (tmout) begin
            rsp_err_q <= 1'b1;
        end
    end

    // read data for the response cycle
    always_ff @(posedge clk) begin
        if (in_req && !is_ext) begin
            rsp_data_q <= (is_int && !is_wr) ? reg_rd_data_i : '0;
        end else if (ext_ack) begin
            rsp_data_q <= is_wr ? '0 : ext_rsp_i.rd_data;
        end else if (tmout) begin
            rsp_data_q <= '0;
        end
    end

    assign apb_o.pready  = state_q == bus_pkg::ST_RESP;
    assign apb_o.pslverr = (state_q == bus_pkg::ST_RESP) && rsp_err_q;
    assign apb_o.prdata  = rsp_data_q;

    // native port, command held while outstanding
    assign ext_req_o.req_vld = is_ext && in_req;
    assign ext_req_o.wr_en   = ext_busy && is_wr;
    assign ext_req_o.rd_en   = ext_busy && !is_wr;
    assign ext_req_o.addr    = acc_i.addr;
    assign ext_req_o.wr_data = acc_i.wr_data;

    // debug register strobes
    assign reg_acc_o.wr_en   = in_req && is_int && is_wr;
    assign reg_acc_o.rd_en   = in_req && is_int && !is_wr;
    assign reg_acc_o.target  = acc_i.target;
    assign reg_acc_o.wr_data = acc_i.wr_data;

    assign err_evt_o.valid    = tmout;
    assign err_evt_o.addr     = acc_i.addr;
    assign err_evt_o.is_write = is_wr;

endmodule

`default_nettype wire

/* logic/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // APB master side
    typedef struct packed {
        logic                               psel;
        logic                               penable;
        logic                               pwrite;
        logic [reg_map_pkg::ADDR_W-1:0]     paddr;
        logic [reg_map_pkg::DATA_W-1:0]     pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                               pready;
        logic                               pslverr;
        logic [reg_map_pkg::DATA_W-1:0]     prdata;
    } apb_rsp_t;

    // native register port towards the downstream block
    typedef struct packed {
        logic                               req_vld;
        logic                               wr_en;
        logic                               rd_en;
        logic [reg_map_pkg::ADDR_W-1:0]     addr;
        logic [reg_map_pkg::DATA_W-1:0]     wr_data;
    } native_req_t;

    typedef struct packed {
        logic                               ack_vld;
        logic [reg_map_pkg::DATA_W-1:0]     rd_data;
    } native_rsp_t;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } access_op_e;

    // one decoded APB transfer
    typedef struct packed {
        access_op_e                         op;
        reg_map_pkg::target_e               target;
        logic [reg_map_pkg::ADDR_W-1:0]     addr;
        logic [reg_map_pkg::DATA_W-1:0]     wr_data;
    } access_t;

    // strobe into the debug registers
    typedef struct packed {
        logic                               wr_en;
        logic                               rd_en;
        reg_map_pkg::target_e               target;
        logic [reg_map_pkg::DATA_W-1:0]     wr_data;
    } reg_acc_t;

    // timeout report
    typedef struct packed {
        logic                               valid;
        logic [reg_map_pkg::ADDR_W-1:0]     addr;
        logic                               is_write;
    } err_evt_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_RESP
    } fsm_state_e;

endpackage

`default_nettype wire

/* logic/debug_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_regs #(
    parameter int unsigned TMR_THR_RST = 99,
    parameter int unsigned TMR_W       = 32
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  bus_pkg::reg_acc_t                   reg_acc_i,
    output logic [reg_map_pkg::DATA_W-1:0]      reg_rd_data_o,
    input  bus_pkg::err_evt_t                   err_evt_i,
    output logic [TMR_W-1:0]                    tmr_thr_o,
    output logic                                ext_soft_rst_o
);

    logic [reg_map_pkg::ADDR_W-1:0]     err_addr_q;
    logic [reg_map_pkg::DATA_W-1:0]     snap_hi_q;
    logic [TMR_W-1:0]                   tmr_thr_q;
    logic                               soft_rst_q;
    logic                               err_occur_q;
    logic                               err_acc_type_q;
    logic                               wr_thr;
    logic                               wr_stat;
    logic                               rd_lo;
    logic [reg_map_pkg::DATA_W-1:0]     thr_word;
    logic [reg_map_pkg::DATA_W-1:0]     stat_word;

    assign wr_thr  = reg_acc_i.wr_en && (reg_acc_i.target == reg_map_pkg::TGT_TMR_THR);
    assign wr_stat = reg_acc_i.wr_en && (reg_acc_i.target == reg_map_pkg::TGT_ERR_STAT);
    assign rd_lo   = reg_acc_i.rd_en && (reg_acc_i.target == reg_map_pkg::TGT_ERR_ADDR_LO);

    // failing address, hardware only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_addr_q <= '0;
        end else if (err_evt_i.valid) begin
            err_addr_q <= err_evt_i.addr;
        end
    end

    // high half frozen by a low half read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snap_hi_q <= '0;
        end else if (soft_rst_q) begin
            snap_hi_q <= '0;
        end else if (rd_lo) begin
            snap_hi_q <= err_addr_q[reg_map_pkg::ADDR_W-1:reg_map_pkg::DATA_W];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmr_thr_q <= TMR_W'(TMR_THR_RST);
        end else if (wr_thr) begin
            tmr_thr_q <= reg_acc_i.wr_data[TMR_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            soft_rst_q     <= 1'b0;
            err_occur_q    <= 1'b0;
            err_acc_type_q <= 1'b0;
        end else begin
            if (wr_stat) begin
                soft_rst_q <= reg_acc_i.wr_data[reg_map_pkg::SOFT_RST_BIT];
            end
            // software write beats the timeout event
            if (wr_stat) begin
                err_occur_q <= reg_acc_i.wr_data[reg_map_pkg::ERR_OCCUR_BIT];
            end else if (err_evt_i.valid) begin
                err_occur_q <= 1'b1;
            end
            // read-only for software
            if (err_evt_i.valid) begin
                err_acc_type_q <= err_evt_i.is_write;
            end
        end
    end

    // read mux, answered in the strobe cycle
    always_comb begin
        thr_word  = '0;
        thr_word[TMR_W-1:0] = tmr_thr_q;
        stat_word = '0;
        stat_word[reg_map_pkg::SOFT_RST_BIT]     = soft_rst_q;
        stat_word[reg_map_pkg::ERR_OCCUR_BIT]    = err_occur_q;
        stat_word[reg_map_pkg::ERR_ACC_TYPE_BIT] = err_acc_type_q;
        case (reg_acc_i.target)
            reg_map_pkg::TGT_ERR_ADDR_LO: reg_rd_data_o = err_addr_q[reg_map_pkg::DATA_W-1:0];
            reg_map_pkg::TGT_ERR_ADDR_HI: reg_rd_data_o = snap_hi_q;
            reg_map_pkg::TGT_TMR_THR:     reg_rd_data_o = thr_word;
            reg_map_pkg::TGT_ERR_STAT:    reg_rd_data_o = stat_word;
            default:                      reg_rd_data_o = '0;
        endcase
    end

    assign tmr_thr_o      = tmr_thr_q;
    // level to downstream logic
    assign ext_soft_rst_o = soft_rst_q;

endmodule

`default_nettype wire

/* logic/reg_map_pkg.sv */
`default_nettype none

package reg_map_pkg;

    // bus widths
    localparam int unsigned ADDR_W = 64;
    localparam int unsigned DATA_W = 32;

    // addresses with this bit set belong to the downstream register block
    localparam int unsigned EXT_SEL_BIT = 12;

    // internal debug register byte addresses
    localparam logic [ADDR_W-1:0] ERR_ADDR_LO_ADDR = 64'h4;
    localparam logic [ADDR_W-1:0] ERR_ADDR_HI_ADDR = 64'h10;
    localparam logic [ADDR_W-1:0] TMR_THR_ADDR     = 64'h14;
    localparam logic [ADDR_W-1:0] ERR_STAT_ADDR    = 64'h18;

    // err_stat fields
    localparam int unsigned SOFT_RST_BIT     = 0;
    localparam int unsigned ERR_OCCUR_BIT    = 1;
    localparam int unsigned ERR_ACC_TYPE_BIT = 2;

    // decode result
    typedef enum logic [2:0] {
        TGT_EXT,
        TGT_ERR_ADDR_LO,
        TGT_ERR_ADDR_HI,
        TGT_TMR_THR,
        TGT_ERR_STAT,
        TGT_UNMAPPED
    } target_e;

endpackage

`default_nettype wire

/* logic/reg_master_top.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_master_top #(
    parameter int unsigned TMR_W       = 32,
    parameter int unsigned TMR_THR_RST = 99
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bus_pkg::apb_req_t       apb_i,
    output bus_pkg::apb_rsp_t       apb_o,
    output bus_pkg::native_req_t    ext_req_o,
    input  bus_pkg::native_rsp_t    ext_rsp_i,
    output logic                    ext_soft_rst_o
);

    bus_pkg::access_t                   acc;
    logic                               acc_vld;
    bus_pkg::reg_acc_t                  reg_acc;
    bus_pkg::err_evt_t                  err_evt;
    logic [reg_map_pkg::DATA_W-1:0]     reg_rd_data;
    logic [TMR_W-1:0]                   tmr_thr;

    // APB setup capture and address decode
    access_decode u_access_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_i      (apb_i),
        .acc_o      (acc),
        .acc_vld_o  (acc_vld)
    );

    // transfer control and timeout
    access_fsm #(
        .TMR_W          (TMR_W)
    ) u_access_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .acc_i          (acc),
        .acc_vld_i      (acc_vld),
        .tmr_thr_i      (tmr_thr),
        .ext_req_o      (ext_req_o),
        .ext_rsp_i      (ext_rsp_i),
        .reg_acc_o      (reg_acc),
        .reg_rd_data_i  (reg_rd_data),
        .err_evt_o      (err_evt),
        .apb_o          (apb_o)
    );

    // debug registers
    debug_regs #(
        .TMR_THR_RST    (TMR_THR_RST),
        .TMR_W          (TMR_W)
    ) u_debug_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .reg_acc_i      (reg_acc),
        .reg_rd_data_o  (reg_rd_data),
        .err_evt_i      (err_evt),
        .tmr_thr_o      (tmr_thr),
        .ext_soft_rst_o (ext_soft_rst_o)
    );

endmodule

`default_nettype wire

/* reg_master.f */
logic/reg_map_pkg.sv
logic/bus_pkg.sv
logic/access_decode.sv
logic/access_fsm.sv
logic/debug_regs.sv
logic/reg_master_top.sv
verif/tb_clock_gen.sv
verif/reg_master_properties.sv
verif/reg_master_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f reg_master.f \
    --top-module reg_master_tb \
    -o sim_reg_master

./obj_dir/sim_reg_master +verilator+error+limit+100 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation finished without failures"

/* verif/reg_master_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_master_properties (
    input logic                     clk,
    input logic                     rst_n,
    input bus_pkg::apb_rsp_t        apb_rsp_i,
    input bus_pkg::native_req_t     ext_req_i
);

    // failures seen so far, read by the testbench
    int unsigned fail_cnt = 0;

    a_pready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp_i.pready |=> !apb_rsp_i.pready)
    else begin
        fail_cnt++;
        $error("pready high in two consecutive cycles");
    end

    a_pslverr_with_pready: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp_i.pslverr |-> apb_rsp_i.pready)
    else begin
        fail_cnt++;
        $error("pslverr high without pready");
    end

    a_req_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ext_req_i.req_vld |=> !ext_req_i.req_vld)
    else begin
        fail_cnt++;
        $error("req_vld longer than one cycle");
    end

    a_wr_rd_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ext_req_i.wr_en && ext_req_i.rd_en))
    else begin
        fail_cnt++;
        $error("wr_en and rd_en set together");
    end

endmodule

bind reg_master_top reg_master_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .apb_rsp_i  (apb_o),
    .ext_req_i  (ext_req_o)
);

`default_nettype wire

/* verif/reg_master_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_master_tb;

    logic                   clk;
    logic                   rst_n;
    bus_pkg::apb_req_t      apb_req;
    bus_pkg::apb_rsp_t      apb_rsp;
    bus_pkg::native_req_t   ext_req;
    bus_pkg::native_rsp_t   ext_rsp;
    logic                   ext_soft_rst;

    int                     errors;
    int                     checks;
    int                     err_mark;
    logic [31:0]            rng_state;

    // register model
    logic [31:0]            m_thr;
    logic                   m_soft;
    logic                   m_occur;
    logic                   m_acc_type;
    logic [63:0]            m_err_addr;
    logic [31:0]            m_snap;

    tb_clock_gen u_clock_gen (
        .clk    (clk),
        .rst_n  (rst_n)
    );

    reg_master_top #(
        .TMR_W          (32),
        .TMR_THR_RST    (99)
    ) uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .apb_i          (apb_req),
        .apb_o          (apb_rsp),
        .ext_req_o      (ext_req),
        .ext_rsp_i      (ext_rsp),
        .ext_soft_rst_o (ext_soft_rst)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: time %0t signal %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // expected read data, with the snapshot side effect of a low half read
    function automatic logic [31:0] model_read(input logic [63:0] addr);
        logic [31:0] val;
        val = '0;
        if (!addr[12]) begin
            case (addr)
                reg_map_pkg::ERR_ADDR_LO_ADDR: begin
                    val = m_err_addr[31:0];
                    if (!m_soft) begin
                        m_snap = m_err_addr[63:32];
                    end
                end
                reg_map_pkg::ERR_ADDR_HI_ADDR: val = m_snap;
                reg_map_pkg::TMR_THR_ADDR:     val = m_thr;
                reg_map_pkg::ERR_STAT_ADDR:    val = {29'b0, m_acc_type, m_occur, m_soft};
                default:                       val = '0;
            endcase
        end
        return val;
    endfunction

    function automatic void model_write(input logic [63:0] addr, input logic [31:0] data);
        if (!addr[12]) begin
            case (addr)
                reg_map_pkg::TMR_THR_ADDR: m_thr = data;
                reg_map_pkg::ERR_STAT_ADDR: begin
                    m_soft  = data[0];
                    m_occur = data[1];
                end
                default: ;
            endcase
        end
        // snapshot stays clear while soft reset is active
        if (m_soft) begin
            m_snap = '0;
        end
    endfunction

    task automatic apb_start(input logic wr, input logic [63:0] addr, input logic [31:0] data);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge clk);
        apb_req.penable <= 1'b1;
    endtask

    // waits for pready, then closes the transfer
    task automatic apb_finish(input int max_cycles, output logic err, output logic [31:0] rdata);
        int n;
        n = 0;
        @(negedge clk);
        while (apb_rsp.pready !== 1'b1 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (apb_rsp.pready !== 1'b1) begin
            errors++;
            $display("pready did not arrive within %0d cycles at time %0t", max_cycles, $time);
        end
        err   = apb_rsp.pslverr;
        rdata = apb_rsp.prdata;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_access(input logic wr, input logic [63:0] addr, input logic [31:0] data,
                              output logic err, output logic [31:0] rdata);
        apb_start(wr, addr, data);
        apb_finish(8, err, rdata);
    endtask

    // downstream responder, silent when answer is low
    task automatic respond_ext(input logic answer, input int delay, input logic [31:0] data);
        if (answer) begin
            @(posedge clk);
            repeat (delay) @(posedge clk);
            ext_rsp.ack_vld <= 1'b1;
            ext_rsp.rd_data <= data;
            @(posedge clk);
            ext_rsp.ack_vld <= 1'b0;
        end
    endtask

    task automatic ext_access(input logic wr, input logic [63:0] addr, input logic [31:0] data,
                              input logic answer, input int delay, input logic [31:0] rsp_data,
                              input int max_cycles, output logic err, output logic [31:0] rdata);
        int n;
        apb_start(wr, addr, data);
        n = 0;
        @(negedge clk);
        while (ext_req.req_vld !== 1'b1 && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (ext_req.req_vld !== 1'b1) begin
            errors++;
            $display("no native request for address %h at time %0t", addr, $time);
        end else begin
            check_value("ext_req_o.addr", addr, ext_req.addr);
            check_value("ext_req_o.wr_data", data, ext_req.wr_data);
            check_value("ext_req_o.wr_en", wr, ext_req.wr_en);
            check_value("ext_req_o.rd_en", !wr, ext_req.rd_en);
            respond_ext(answer, delay, rsp_data);
        end
        apb_finish(max_cycles, err, rdata);
    endtask

    task automatic reg_read(input logic [63:0] addr, input string name);
        logic        err;
        logic [31:0] rdata;
        logic [31:0] exp;
        exp = model_read(addr);
        apb_access(1'b0, addr, '0, err, rdata);
        check_value({name, " pslverr"}, 1'b0, err);
        check_value({name, " prdata"}, exp, rdata);
    endtask

    task automatic reg_write(input logic [63:0] addr, input logic [31:0] data,
                             input string name);
        logic        err;
        logic [31:0] rdata;
        apb_access(1'b1, addr, data, err, rdata);
        model_write(addr, data);
        check_value({name, " pslverr"}, 1'b0, err);
        check_value({name, " prdata"}, '0, rdata);
    endtask

    task automatic soft_rst_check();
        @(negedge clk);
        check_value("ext_soft_rst_o", m_soft, ext_soft_rst);
    endtask

    task automatic read_all_regs();
        reg_read(reg_map_pkg::ERR_ADDR_LO_ADDR, "err_addr_lo");
        reg_read(reg_map_pkg::ERR_ADDR_HI_ADDR, "err_addr_hi");
        reg_read(reg_map_pkg::TMR_THR_ADDR, "tmr_thr");
        reg_read(reg_map_pkg::ERR_STAT_ADDR, "err_stat");
    endtask

    task automatic end_test(input string name);
        $display("%s finished, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        logic [63:0] addr;
        logic [63:0] int_addr [4];
        logic [31:0] a_hi;
        logic [31:0] a_lo;
        logic [31:0] data;
        logic [31:0] rsp_data;
        logic [31:0] pick;
        logic [31:0] rdata;
        logic        wr;
        logic        err;
        int          n;

        apb_req    = '0;
        ext_rsp    = '0;
        errors     = 0;
        checks     = 0;
        err_mark   = 0;
        rng_state  = 32'h998;
        m_thr      = 32'd99;
        m_soft     = 1'b0;
        m_occur    = 1'b0;
        m_acc_type = 1'b0;
        m_err_addr = '0;
        m_snap     = '0;
        int_addr[0] = reg_map_pkg::ERR_ADDR_LO_ADDR;
        int_addr[1] = reg_map_pkg::ERR_ADDR_HI_ADDR;
        int_addr[2] = reg_map_pkg::TMR_THR_ADDR;
        int_addr[3] = reg_map_pkg::ERR_STAT_ADDR;

        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("reset was never released");
        end

        // 1: reset values
        read_all_regs();
        soft_rst_check();
        end_test("test 1 reset values");

        // 2: random internal accesses
        for (int i = 0; i < 24; i++) begin
            pick = next_rand();
            data = next_rand();
            if (pick[2]) begin
                reg_write(int_addr[pick[1:0]], data, "internal write");
            end else begin
                reg_read(int_addr[pick[1:0]], "internal read");
            end
            soft_rst_check();
        end
        // access type bit is read only
        reg_write(reg_map_pkg::ERR_STAT_ADDR, 32'h7, "err_stat");
        reg_read(reg_map_pkg::ERR_STAT_ADDR, "err_stat");
        end_test("test 2 internal registers");

        // 3: external forwarding with acks well below the threshold
        reg_write(reg_map_pkg::TMR_THR_ADDR, 32'd64, "tmr_thr");
        for (int i = 0; i < 12; i++) begin
            a_hi = next_rand();
            a_lo = next_rand();
            addr = {a_hi, a_lo};
            addr[reg_map_pkg::EXT_SEL_BIT] = 1'b1;
            pick = next_rand();
            wr = pick[0];
            data = next_rand();
            rsp_data = next_rand();
            ext_access(wr, addr, data, 1'b1, int'(pick[4:1]), rsp_data, 100, err, rdata);
            check_value("pslverr", 1'b0, err);
            check_value("prdata", wr ? 32'h0 : rsp_data, rdata);
        end
        end_test("test 3 external forwarding");

        // 4: timeout with a silent downstream
        reg_write(reg_map_pkg::ERR_STAT_ADDR, 32'h0, "err_stat");
        reg_write(reg_map_pkg::TMR_THR_ADDR, 32'd5, "tmr_thr");
        for (int i = 0; i < 2; i++) begin
            a_hi = next_rand();
            a_lo = next_rand();
            addr = {a_hi, a_lo};
            addr[reg_map_pkg::EXT_SEL_BIT] = 1'b1;
            wr = (i == 1);
            data = next_rand();
            ext_access(wr, addr, data, 1'b0, 0, '0, 40, err, rdata);
            check_value("pslverr", 1'b1, err);
            check_value("prdata", '0, rdata);
            m_err_addr = addr;
            m_occur    = 1'b1;
            m_acc_type = wr;
            reg_read(reg_map_pkg::ERR_STAT_ADDR, "err_stat");
            reg_read(reg_map_pkg::ERR_ADDR_LO_ADDR, "err_addr_lo");
            reg_read(reg_map_pkg::ERR_ADDR_HI_ADDR, "err_addr_hi");
        end
        end_test("test 4 timeout and error capture");

        // 5: unmapped addresses
        for (int i = 0; i < 10; i++) begin
            a_hi = next_rand();
            a_lo = next_rand();
            addr = {a_hi, a_lo};
            addr[reg_map_pkg::EXT_SEL_BIT] = 1'b0;
            if (addr[63:5] == '0) begin
                addr[20] = 1'b1;
            end
            pick = next_rand();
            if (pick[0]) begin
                reg_write(addr, next_rand(), "unmapped write");
            end else begin
                reg_read(addr, "unmapped read");
            end
        end
        read_all_regs();
        end_test("test 5 unmapped addresses");

        // 6: soft reset level and snapshot clear
        reg_write(reg_map_pkg::ERR_STAT_ADDR, 32'h1, "err_stat");
        soft_rst_check();
        reg_read(reg_map_pkg::ERR_ADDR_HI_ADDR, "err_addr_hi");
        reg_write(reg_map_pkg::ERR_STAT_ADDR, 32'h0, "err_stat");
        soft_rst_check();
        end_test("test 6 soft reset");

        if (uut.u_props.fail_cnt != 0) begin
            errors += int'(uut.u_props.fail_cnt);
            $display("%0d assertion failures", uut.u_props.fail_cnt);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held low for 4 cycles
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire
